// ==== riscv_v_pkg.sv ====
//======================================================================
// Vector slice geometry, vl/vstart widths, element size encoding
// and the data word with its flat and byte views
//======================================================================

package riscv_v_pkg;

    localparam int RISCV_V_NUM_BYTES_DATA          = 16;
    localparam int RISCV_V_DATA_WIDTH              = RISCV_V_NUM_BYTES_DATA * 8;
    localparam int RISCV_V_NUM_VALID_OSIZES        = 5;
    localparam int RISCV_V_NUM_ELEMENTS_REG        = 16;
    localparam int RISCV_V_NUM_BYTES_ALLOCATE_MASK = 2;
    localparam int RISCV_V_VL_WIDTH                = 5;
    localparam int RISCV_V_VSTART_WIDTH            = 4;

    // Same encoding as vsew
    typedef enum logic [2:0] {
        OSIZE_8   = 3'd0,
        OSIZE_16  = 3'd1,
        OSIZE_32  = 3'd2,
        OSIZE_64  = 3'd3,
        OSIZE_128 = 3'd4
    } riscv_v_osize_e;

    // One bit per byte lane
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_byte_vec_t;

    typedef union packed {
        logic [RISCV_V_DATA_WIDTH-1:0]            word;
        logic [RISCV_V_NUM_BYTES_DATA-1:0][7:0]   bytes;
    } riscv_v_data_u;

endpackage

// ==== riscv_v_op_pkg.sv ====
//======================================================================
// Integer ALU operation codes for the vector lane
//======================================================================

package riscv_v_op_pkg;

    localparam int RISCV_V_OP_WIDTH = 3;

    localparam logic [RISCV_V_OP_WIDTH-1:0] OP_ADD = 3'd0;
    localparam logic [RISCV_V_OP_WIDTH-1:0] OP_SUB = 3'd1;
    localparam logic [RISCV_V_OP_WIDTH-1:0] OP_AND = 3'd2;
    localparam logic [RISCV_V_OP_WIDTH-1:0] OP_OR  = 3'd3;
    // Codes above XOR fall back to add
    localparam logic [RISCV_V_OP_WIDTH-1:0] OP_XOR = 3'd4;

endpackage

// ==== riscv_v_issue_stage.sv ====
//======================================================================
// Issue register holding one full vector request
//======================================================================
`timescale 1ns/1ps

module riscv_v_issue_stage
import riscv_v_pkg::*, riscv_v_op_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  riscv_v_data_u                   srca,
    input  riscv_v_data_u                   srcb,
    input  riscv_v_data_u                   vd_old,
    input  riscv_v_osize_e                  vsew,
    input  logic [RISCV_V_VL_WIDTH-1:0]     vl,
    input  logic [RISCV_V_VSTART_WIDTH-1:0] vstart,
    input  riscv_v_byte_vec_t               mask,
    input  logic                            use_mask,
    input  logic                            is_mask,
    input  logic                            is_reduct,
    input  logic [RISCV_V_OP_WIDTH-1:0]     op,
    output logic                            iss_valid,
    input  logic                            iss_ready,
    output riscv_v_data_u                   iss_srca,
    output riscv_v_data_u                   iss_srcb,
    output riscv_v_data_u                   iss_vd_old,
    output riscv_v_osize_e                  iss_vsew,
    output logic [RISCV_V_VL_WIDTH-1:0]     iss_vl,
    output logic [RISCV_V_VSTART_WIDTH-1:0] iss_vstart,
    output riscv_v_byte_vec_t               iss_mask,
    output logic                            iss_use_mask,
    output logic                            iss_is_mask,
    output logic                            iss_is_reduct,
    output logic [RISCV_V_OP_WIDTH-1:0]     iss_op
);

    assign in_ready = ~iss_valid | iss_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else if (in_ready) begin
            iss_valid <= in_valid;
        end
    end

    // Payload only loads on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            iss_srca      <= srca;
            iss_srcb      <= srcb;
            iss_vd_old    <= vd_old;
            iss_vsew      <= vsew;
            iss_vl        <= vl;
            iss_vstart    <= vstart;
            iss_mask      <= mask;
            iss_use_mask  <= use_mask;
            iss_is_mask   <= is_mask;
            iss_is_reduct <= is_reduct;
            iss_op        <= op;
        end
    end

endmodule

// ==== riscv_v_decode_element.sv ====
//======================================================================
// Element decode: per-byte in-range, write-valid and merge words
// from vsew, vl, vstart, mask and the mask/reduction flags
//======================================================================
`timescale 1ns/1ps

module riscv_v_decode_element
import riscv_v_pkg::*;
(
    input  riscv_v_osize_e                  vsew,
    input  logic [RISCV_V_VL_WIDTH-1:0]     vl,
    input  logic [RISCV_V_VSTART_WIDTH-1:0] vstart,
    input  riscv_v_byte_vec_t               mask,
    input  logic                            use_mask,
    input  logic                            is_mask,
    input  logic                            is_reduct,
    output riscv_v_byte_vec_t               srca_valid,
    output riscv_v_byte_vec_t               srcb_valid,
    output riscv_v_byte_vec_t               merge
);

    logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector;
    logic [RISCV_V_NUM_VALID_OSIZES-1:0] is_greater_osize_vector;
    logic [RISCV_V_NUM_VALID_OSIZES-1:0] is_less_osize_vector;

    logic [RISCV_V_NUM_ELEMENTS_REG-1:0] elem_in_range;
    logic [RISCV_V_NUM_ELEMENTS_REG-1:0] elem_active;

    riscv_v_byte_vec_t active_bytes;
    riscv_v_byte_vec_t is_mask_keep;
    riscv_v_byte_vec_t reduct_keep;

    // Number of low zero bits of a byte boundary
    function automatic int boundary_level(input int boundary);
        int level;
        level = 0;
        while (((boundary >> level) & 1) == 0 && level < RISCV_V_NUM_VALID_OSIZES - 1) begin
            level++;
        end
        return level;
    endfunction

    always_comb begin
        for (int osize_idx = 0; osize_idx < RISCV_V_NUM_VALID_OSIZES; osize_idx++) begin
            osize_vector[osize_idx] = (vsew == riscv_v_osize_e'(osize_idx));
        end
    end

    // Size at least / at most a given encoding
    assign is_greater_osize_vector[0] = 1'b1;
    assign is_less_osize_vector[RISCV_V_NUM_VALID_OSIZES-1] = 1'b1;
    for (genvar osize_idx = 1; osize_idx < RISCV_V_NUM_VALID_OSIZES; osize_idx++) begin : gen_size_cmp
        assign is_greater_osize_vector[osize_idx] =
            |osize_vector[RISCV_V_NUM_VALID_OSIZES-1:osize_idx];
        assign is_less_osize_vector[osize_idx-1] = ~is_greater_osize_vector[osize_idx];
    end

    // Per-element vl / vstart range and mask bit
    for (genvar elem_idx = 0; elem_idx < RISCV_V_NUM_ELEMENTS_REG; elem_idx++) begin : gen_elem
        assign elem_in_range[elem_idx] = (vl >= RISCV_V_VL_WIDTH'(elem_idx + 1)) &&
                                         (vstart <= RISCV_V_VSTART_WIDTH'(elem_idx));
        assign elem_active[elem_idx]   = elem_in_range[elem_idx] &
                                         (~use_mask | mask[elem_idx]);
    end

    // Spread element results over the bytes of the selected size
    always_comb begin
        srcb_valid   = '0;
        active_bytes = '0;
        for (int byte_idx = 0; byte_idx < RISCV_V_NUM_BYTES_DATA; byte_idx++) begin
            for (int osize_idx = 0; osize_idx < RISCV_V_NUM_VALID_OSIZES; osize_idx++) begin
                if (osize_vector[osize_idx]) begin
                    srcb_valid[byte_idx]   = elem_in_range[byte_idx >> osize_idx];
                    active_bytes[byte_idx] = elem_active[byte_idx >> osize_idx];
                end
            end
        end
    end

    // Mask destination only takes the low bytes
    assign is_mask_keep = {{(RISCV_V_NUM_BYTES_DATA - RISCV_V_NUM_BYTES_ALLOCATE_MASK){~is_mask}},
                           {RISCV_V_NUM_BYTES_ALLOCATE_MASK{1'b1}}};

    // Byte k lies outside element 0 when the size is at most floor(log2 k)
    assign reduct_keep[0] = 1'b1;
    for (genvar byte_idx = 1; byte_idx < RISCV_V_NUM_BYTES_DATA; byte_idx++) begin : gen_reduct
        localparam int LEVEL = $clog2(byte_idx + 1) - 1;
        assign reduct_keep[byte_idx] = ~(is_reduct & is_less_osize_vector[LEVEL]);
    end

    assign srca_valid = active_bytes & is_mask_keep & reduct_keep;

    // Bytes b and b+1 share an element when the size exceeds the boundary alignment
    for (genvar byte_idx = 0; byte_idx < RISCV_V_NUM_BYTES_DATA - 1; byte_idx++) begin : gen_merge
        localparam int LEVEL = boundary_level(byte_idx + 1);
        assign merge[byte_idx] = is_greater_osize_vector[LEVEL + 1];
    end
    assign merge[RISCV_V_NUM_BYTES_DATA-1] = 1'b0;

endmodule

// ==== riscv_v_lane_alu.sv ====
//======================================================================
// Execute register and byte-lane integer ALU
// Add/sub carries run between bytes of one element via merge
//======================================================================
`timescale 1ns/1ps

module riscv_v_lane_alu
import riscv_v_pkg::*, riscv_v_op_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        iss_valid,
    output logic                        iss_ready,
    input  riscv_v_data_u               srca,
    input  riscv_v_data_u               srcb,
    input  riscv_v_data_u               vd_old,
    input  riscv_v_byte_vec_t           srca_valid,
    input  riscv_v_byte_vec_t           merge,
    input  logic [RISCV_V_OP_WIDTH-1:0] op,
    output logic                        ex_valid,
    input  logic                        ex_ready,
    output riscv_v_data_u               alu_result,
    output riscv_v_byte_vec_t           ex_we,
    output riscv_v_data_u               ex_vd_old
);

    riscv_v_data_u               ex_srca;
    riscv_v_data_u               ex_srcb;
    riscv_v_byte_vec_t           ex_merge;
    logic [RISCV_V_OP_WIDTH-1:0] ex_op;

    logic          is_sub;
    riscv_v_data_u operand_b;
    riscv_v_data_u sum_data;
    logic [8:0]    byte_sum;
    logic          carry_in;

    assign iss_ready = ~ex_valid | ex_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (iss_ready) begin
            ex_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            ex_srca   <= srca;
            ex_srcb   <= srcb;
            ex_vd_old <= vd_old;
            ex_we     <= srca_valid;
            ex_merge  <= merge;
            ex_op     <= op;
        end
    end

    assign is_sub         = (ex_op == OP_SUB);
    assign operand_b.word = is_sub ? ~ex_srcb.word : ex_srcb.word;

    // Ripple per byte; an element's lowest byte restarts with the op carry
    always_comb begin
        sum_data = '0;
        byte_sum = '0;
        carry_in = is_sub;
        for (int byte_idx = 0; byte_idx < RISCV_V_NUM_BYTES_DATA; byte_idx++) begin
            byte_sum = {1'b0, ex_srca.bytes[byte_idx]} + {1'b0, operand_b.bytes[byte_idx]}
                       + {8'd0, carry_in};
            sum_data.bytes[byte_idx] = byte_sum[7:0];
            carry_in = ex_merge[byte_idx] ? byte_sum[8] : is_sub;
        end
    end

    always_comb begin
        case (ex_op)
            OP_ADD, OP_SUB: alu_result = sum_data;
            OP_AND:         alu_result.word = ex_srca.word & ex_srcb.word;
            OP_OR:          alu_result.word = ex_srca.word | ex_srcb.word;
            OP_XOR:         alu_result.word = ex_srca.word ^ ex_srcb.word;
            default:        alu_result = sum_data;
        endcase
    end

endmodule

// ==== riscv_v_writeback_stage.sv ====
//======================================================================
// Writeback register: ALU bytes where enabled, old destination elsewhere
//======================================================================
`timescale 1ns/1ps

module riscv_v_writeback_stage
import riscv_v_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_valid,
    output logic              ex_ready,
    input  riscv_v_data_u     alu_result,
    input  riscv_v_data_u     ex_vd_old,
    input  riscv_v_byte_vec_t ex_we,
    output logic              out_valid,
    input  logic              out_ready,
    output riscv_v_data_u     result,
    output riscv_v_byte_vec_t byte_we
);

    assign ex_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (ex_ready) begin
            out_valid <= ex_valid;
        end
    end

    // Undisturbed policy on inactive bytes
    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            for (int byte_idx = 0; byte_idx < RISCV_V_NUM_BYTES_DATA; byte_idx++) begin
                result.bytes[byte_idx] <= ex_we[byte_idx] ? alu_result.bytes[byte_idx]
                                                          : ex_vd_old.bytes[byte_idx];
            end
            byte_we <= ex_we;
        end
    end

endmodule

// ==== riscv_v_exec_top.sv ====
//======================================================================
// Vector element pipeline top: issue, decode, execute, writeback
//======================================================================
`timescale 1ns/1ps

module riscv_v_exec_top
import riscv_v_pkg::*, riscv_v_op_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  riscv_v_data_u                   srca,
    input  riscv_v_data_u                   srcb,
    input  riscv_v_data_u                   vd_old,
    input  riscv_v_osize_e                  vsew,
    input  logic [RISCV_V_VL_WIDTH-1:0]     vl,
    input  logic [RISCV_V_VSTART_WIDTH-1:0] vstart,
    input  riscv_v_byte_vec_t               mask,
    input  logic                            use_mask,
    input  logic                            is_mask,
    input  logic                            is_reduct,
    input  logic [RISCV_V_OP_WIDTH-1:0]     op,
    output logic                            out_valid,
    input  logic                            out_ready,
    output riscv_v_data_u                   result,
    output riscv_v_byte_vec_t               byte_we
);

    logic                            iss_valid;
    logic                            iss_ready;
    riscv_v_data_u                   iss_srca;
    riscv_v_data_u                   iss_srcb;
    riscv_v_data_u                   iss_vd_old;
    riscv_v_osize_e                  iss_vsew;
    logic [RISCV_V_VL_WIDTH-1:0]     iss_vl;
    logic [RISCV_V_VSTART_WIDTH-1:0] iss_vstart;
    riscv_v_byte_vec_t               iss_mask;
    logic                            iss_use_mask;
    logic                            iss_is_mask;
    logic                            iss_is_reduct;
    logic [RISCV_V_OP_WIDTH-1:0]     iss_op;

    riscv_v_byte_vec_t               srca_valid;
    riscv_v_byte_vec_t               merge;

    logic                            ex_valid;
    logic                            ex_ready;
    riscv_v_data_u                   alu_result;
    riscv_v_byte_vec_t               ex_we;
    riscv_v_data_u                   ex_vd_old;

    riscv_v_issue_stage issue0 (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .srca          (srca),
        .srcb          (srcb),
        .vd_old        (vd_old),
        .vsew          (vsew),
        .vl            (vl),
        .vstart        (vstart),
        .mask          (mask),
        .use_mask      (use_mask),
        .is_mask       (is_mask),
        .is_reduct     (is_reduct),
        .op            (op),
        .iss_valid     (iss_valid),
        .iss_ready     (iss_ready),
        .iss_srca      (iss_srca),
        .iss_srcb      (iss_srcb),
        .iss_vd_old    (iss_vd_old),
        .iss_vsew      (iss_vsew),
        .iss_vl        (iss_vl),
        .iss_vstart    (iss_vstart),
        .iss_mask      (iss_mask),
        .iss_use_mask  (iss_use_mask),
        .iss_is_mask   (iss_is_mask),
        .iss_is_reduct (iss_is_reduct),
        .iss_op        (iss_op)
    );

    // Writes follow srca_valid only
    riscv_v_decode_element decode0 (
        .vsew       (iss_vsew),
        .vl         (iss_vl),
        .vstart     (iss_vstart),
        .mask       (iss_mask),
        .use_mask   (iss_use_mask),
        .is_mask    (iss_is_mask),
        .is_reduct  (iss_is_reduct),
        .srca_valid (srca_valid),
        .srcb_valid (),
        .merge      (merge)
    );

    riscv_v_lane_alu alu0 (
        .clk        (clk),
        .reset      (reset),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .srca       (iss_srca),
        .srcb       (iss_srcb),
        .vd_old     (iss_vd_old),
        .srca_valid (srca_valid),
        .merge      (merge),
        .op         (iss_op),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .alu_result (alu_result),
        .ex_we      (ex_we),
        .ex_vd_old  (ex_vd_old)
    );

    riscv_v_writeback_stage wb0 (
        .clk        (clk),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .alu_result (alu_result),
        .ex_vd_old  (ex_vd_old),
        .ex_we      (ex_we),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .result     (result),
        .byte_we    (byte_we)
    );

endmodule

// ==== tb_riscv_v_exec.sv ====
//======================================================================
// Testbench for the vector element pipeline: reference model,
// directed and random requests, back-pressure and in-order checks
//======================================================================
`timescale 1ns/1ps

module tb_riscv_v_exec
import riscv_v_pkg::*, riscv_v_op_pkg::*;
;

    localparam int NUM_RANDOM     = 400;
    // Latency, add/sub, range, mask ops, flags, random
    localparam int NUM_REQUESTS   = 1 + 40 + 30 + 30 + 10 + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 8 + 200;

    logic                            clk;
    logic                            reset;
    logic                            in_valid;
    logic                            in_ready;
    riscv_v_data_u                   srca;
    riscv_v_data_u                   srcb;
    riscv_v_data_u                   vd_old;
    riscv_v_osize_e                  vsew;
    logic [RISCV_V_VL_WIDTH-1:0]     vl;
    logic [RISCV_V_VSTART_WIDTH-1:0] vstart;
    riscv_v_byte_vec_t               mask;
    logic                            use_mask;
    logic                            is_mask;
    logic                            is_reduct;
    logic [RISCV_V_OP_WIDTH-1:0]     op;
    logic                            out_valid;
    logic                            out_ready;
    riscv_v_data_u                   result;
    riscv_v_byte_vec_t               byte_we;

    integer       seed;
    integer       bp_seed;
    logic         bp_enable = 1'b0;
    int           errors = 0;
    int           checks = 0;
    int           in_count = 0;
    int           out_count = 0;
    int           cycle = 0;
    int           timeout_count = 0;
    logic [143:0] exp_q[$];
    int           accept_q[$];
    logic         stalled = 1'b0;
    logic [127:0] held_result;
    logic [15:0]  held_we;

    riscv_v_exec_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .srca      (srca),
        .srcb      (srcb),
        .vd_old    (vd_old),
        .vsew      (vsew),
        .vl        (vl),
        .vstart    (vstart),
        .mask      (mask),
        .use_mask  (use_mask),
        .is_mask   (is_mask),
        .is_reduct (is_reduct),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .byte_we   (byte_we)
    );

    always #10 clk = ~clk;

    function automatic logic [127:0] rand_data();
        logic [127:0] value;
        value[31:0]   = $random(seed);
        value[63:32]  = $random(seed);
        value[95:64]  = $random(seed);
        value[127:96] = $random(seed);
        return value;
    endfunction

    function automatic int pick(input int range);
        return $unsigned($random(seed)) % range;
    endfunction

    // Expected {byte_we, result} computed element by element at the vsew width
    function automatic logic [143:0] model_request(
        input logic [127:0] a,
        input logic [127:0] b,
        input logic [127:0] old,
        input int           sew,
        input int           req_vl,
        input int           req_vstart,
        input logic [15:0]  req_mask,
        input logic         req_use_mask,
        input logic         req_is_mask,
        input logic         req_is_reduct,
        input logic [2:0]   req_op
    );
        int           ebytes;
        logic [127:0] emask;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] er;
        logic [127:0] data;
        logic [15:0]  we;
        logic         active;
        ebytes = 1 << sew;
        emask  = (ebytes == 16) ? '1 : ((128'd1 << (ebytes * 8)) - 1);
        data   = old;
        we     = '0;
        for (int e = 0; e < 16 / ebytes; e++) begin
            ea = (a >> (e * ebytes * 8)) & emask;
            eb = (b >> (e * ebytes * 8)) & emask;
            case (req_op)
                OP_SUB:  er = ea - eb;
                OP_AND:  er = ea & eb;
                OP_OR:   er = ea | eb;
                OP_XOR:  er = ea ^ eb;
                default: er = ea + eb;
            endcase
            er = er & emask;
            active = (e >= req_vstart) && (e < req_vl) &&
                     (!req_use_mask || req_mask[e]) && (!req_is_reduct || e == 0);
            for (int k = 0; k < ebytes; k++) begin
                if (active && (!req_is_mask || (e * ebytes + k) < 2)) begin
                    we[e * ebytes + k]             = 1'b1;
                    data[(e * ebytes + k) * 8 +: 8] = er[k * 8 +: 8];
                end
            end
        end
        return {we, data};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    // Holds the request until the DUT takes it
    task automatic send_request(
        input logic [127:0] a,
        input logic [127:0] b,
        input int           sew,
        input int           req_vl,
        input int           req_vstart,
        input logic [15:0]  req_mask,
        input logic         req_use_mask,
        input logic         req_is_mask,
        input logic         req_is_reduct,
        input logic [2:0]   req_op
    );
        in_valid       <= 1'b1;
        srca.word      <= a;
        srcb.word      <= b;
        vd_old.word    <= rand_data();
        vsew           <= riscv_v_osize_e'(sew);
        vl             <= req_vl[RISCV_V_VL_WIDTH-1:0];
        vstart         <= req_vstart[RISCV_V_VSTART_WIDTH-1:0];
        mask           <= req_mask;
        use_mask       <= req_use_mask;
        is_mask        <= req_is_mask;
        is_reduct      <= req_is_reduct;
        op             <= req_op;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // Random back-pressure stalls 1 in 4 cycles
    always @(posedge clk) begin
        if (bp_enable) begin
            out_ready <= ($random(bp_seed) & 3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Records accepted requests and compares each output transfer
    always @(posedge clk) begin
        logic [143:0] expected;
        int           accepted_at;
        int           in_flight;
        if (!reset) begin
            // Three stages hold at most three requests
            in_flight = in_count - out_count;
            check_value("in_ready", in_ready, (in_flight < 3) || out_ready);
            if (stalled) begin
                check_value("out_valid (stalled)", out_valid, 1'b1);
                check_value("result (stalled)", result, held_result);
                check_value("byte_we (stalled)", byte_we, held_we);
            end
            if (out_valid && in_count == 0) begin
                report_error("out_valid went high before any request was accepted");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("output transfer with no request pending");
                end else begin
                    expected    = exp_q.pop_front();
                    accepted_at = accept_q.pop_front();
                    if (out_count == 0) begin
                        check_value("first output latency", cycle - accepted_at, 3);
                    end
                    check_value("result", result, expected[127:0]);
                    check_value("byte_we", byte_we, expected[143:128]);
                end
                out_count++;
            end
            stalled     = out_valid && !out_ready;
            held_result = result;
            held_we     = byte_we;
            if (in_valid && in_ready) begin
                exp_q.push_back(model_request(srca.word, srcb.word, vd_old.word, int'(vsew),
                                              vl, vstart, mask, use_mask, is_mask,
                                              is_reduct, op));
                accept_q.push_back(cycle);
                in_count++;
            end
        end
        cycle++;
    end

    always @(posedge clk) begin
        timeout_count++;
        if (timeout_count > TIMEOUT_CYCLES) begin
            report_error($sformatf("timeout with %0d requests still waiting for output",
                                   exp_q.size()));
            $display("checks=%0d errors=%0d requests=%0d outputs=%0d",
                     checks, errors, in_count, out_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [2:0] op_code;
        int         sew_sel;
        int         vl_sel;
        int         vstart_sel;
        int         idle;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        srca        = '0;
        srcb        = '0;
        vd_old      = '0;
        vsew        = OSIZE_8;
        vl          = '0;
        vstart      = '0;
        mask        = '0;
        use_mask    = 1'b0;
        is_mask     = 1'b0;
        is_reduct   = 1'b0;
        op          = OP_ADD;
        out_ready   = 1'b1;
        seed        = 32'hdf796e59;
        bp_seed     = seed ^ 32'h3c3c3c3c;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Quiet output after reset then one request for the latency check
        repeat (5) @(posedge clk);
        send_request(rand_data(), rand_data(), 2, 16, 0, '0, 1'b0, 1'b0, 1'b0, OP_ADD);
        while (out_count == 0) begin
            @(posedge clk);
        end

        // Add/sub at every width; the first pair forces carries and borrows
        for (int sew = 0; sew < 5; sew++) begin
            for (int k = 0; k < 2; k++) begin
                op_code = (k == 1) ? OP_SUB : OP_ADD;
                send_request((k == 1) ? '0 : '1, {16{8'h01}}, sew, 16, 0, '0,
                             1'b0, 1'b0, 1'b0, op_code);
                repeat (3) begin
                    send_request(rand_data(), rand_data(), sew, 16, 0, '0,
                                 1'b0, 1'b0, 1'b0, op_code);
                end
            end
        end

        // Random vl and vstart
        repeat (30) begin
            sew_sel    = pick(5);
            vl_sel     = pick(32);
            vstart_sel = pick(16);
            op_code    = pick(5);
            send_request(rand_data(), rand_data(), sew_sel, vl_sel, vstart_sel, '0,
                         1'b0, 1'b0, 1'b0, op_code);
        end

        // Masked logical ops
        for (int i = 0; i < 30; i++) begin
            sew_sel = pick(5);
            op_code = OP_AND + (i % 3);
            send_request(rand_data(), rand_data(), sew_sel, 16, 0, pick(65536),
                         1'b1, 1'b0, 1'b0, op_code);
        end

        for (int sew = 0; sew < 5; sew++) begin
            send_request(rand_data(), rand_data(), sew, 16, 0, '0, 1'b0, 1'b0, 1'b1, OP_ADD);
            send_request(rand_data(), rand_data(), sew, 16, 0, '0, 1'b0, 1'b1, 1'b0, OP_XOR);
        end

        // Fully random traffic with gaps and back-pressure
        bp_enable <= 1'b1;
        repeat (NUM_RANDOM) begin
            idle = pick(3);
            repeat (idle) @(posedge clk);
            sew_sel    = pick(5);
            vl_sel     = pick(32);
            vstart_sel = pick(16);
            op_code    = pick(8);
            send_request(rand_data(), rand_data(), sew_sel, vl_sel, vstart_sel, pick(65536),
                         pick(2), pick(2), pick(2), op_code);
        end
        bp_enable <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (out_count != in_count) begin
            report_error($sformatf("%0d outputs seen for %0d accepted requests",
                                   out_count, in_count));
        end
        $display("checks=%0d errors=%0d requests=%0d outputs=%0d",
                 checks, errors, in_count, out_count);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== build.f ====
riscv_v_pkg.sv
riscv_v_op_pkg.sv
riscv_v_issue_stage.sv
riscv_v_decode_element.sv
riscv_v_lane_alu.sv
riscv_v_writeback_stage.sv
riscv_v_exec_top.sv
tb_riscv_v_exec.sv
